//--- list.f
+incdir+.
rv_dec_pkg.sv
uop_if.sv
rv_imm_gen.sv
rv_decode_stage.sv
uop_fifo.sv
uop_axi_reader.sv
rv_dec_top.sv
tb_rv_dec.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -f list.f --top-module tb_rv_dec -o sim_tb > build.log 2>&1 &&
	./obj_dir/sim_tb > sim.log 2>&1 ||
	echo "build or simulation error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && exit 0 || exit 1

//--- rv_dec_params.svh
`ifndef RV_DEC_PARAMS_SVH
`define RV_DEC_PARAMS_SVH

// instruction word width
`define RV_ILEN 32

// width of program counters and immediates
`define RV_XLEN 32

// decoded micro-ops held between the decode stage and the reader
`define RV_FIFO_DEPTH 4

// reader register map
`define RV_REG_CTRL 32'h0000_0000
`define RV_REG_IMM 32'h0000_0004

`endif

//--- rv_dec_pkg.sv
`include "rv_dec_params.svh"

package rv_dec_pkg;

	typedef logic [`RV_ILEN-1:0] instr_t;
	typedef logic [`RV_XLEN-1:0] pc_t;
	typedef logic [`RV_XLEN-1:0] imm_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [31:0] word_t;

	// W-forms share the operation of their base form
	typedef enum logic [4:0] {
		ALU_NONE,
		ADD,
		SUB,
		MUL,
		MULH,
		MULHSU,
		MULHU,
		DIV,
		DIVU,
		REM,
		REMU,
		SLL,
		SRL,
		SRA,
		XOR,
		OR,
		AND,
		LESS,
		LESSU,
		SLTIU,
		EQUAL,
		NEQ,
		GTE,
		GTEU,
		JUMP,
		IMMVAL
	} alu_op_t;

	typedef enum logic [2:0] {T_NONE, T_R, T_I, T_S, T_SB, T_U, T_UJ} instr_type_t;

	typedef enum logic [1:0] {MA_NONE, MA_READ, MA_WRITE} mem_access_t;

	// order follows the load funct3 encoding, offset by one
	typedef enum logic [2:0] {MS_NONE, BYTE, HALF, WORD, DOUBLE, UBYTE, UHALF, UWORD} mem_size_t;

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} resp_t;

	// control word layout, bits 31:30 read as zero
	localparam int CW_RD_LSB = 0;
	localparam int CW_RS1_LSB = 5;
	localparam int CW_RS2_LSB = 10;
	localparam int CW_ALU_LSB = 15;
	localparam int CW_TYPE_LSB = 20;
	localparam int CW_MACC_LSB = 23;
	localparam int CW_MSIZE_LSB = 25;
	localparam int CW_RW_BIT = 28;
	localparam int CW_ECALL_BIT = 29;

endpackage

//--- rv_dec_top.sv
module rv_dec_top (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_awvalid,
	input  rv_dec_pkg::pc_t    i_awaddr,
	output logic               o_awready,
	input  logic               i_wvalid,
	input  rv_dec_pkg::instr_t i_wdata,
	output logic               o_wready,
	input  logic               i_bready,
	output logic               o_bvalid,
	output rv_dec_pkg::resp_t  o_bresp,
	input  logic               i_arvalid,
	input  rv_dec_pkg::word_t  i_araddr,
	output logic               o_arready,
	input  logic               i_rready,
	output logic               o_rvalid,
	output rv_dec_pkg::word_t  o_rdata,
	output rv_dec_pkg::resp_t  o_rresp
);

	// decode stage to FIFO, FIFO to reader
	uop_if dec_uop ();
	uop_if head_uop ();

	rv_decode_stage u_decode_stage (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_awvalid (i_awvalid),
		.i_awaddr  (i_awaddr),
		.o_awready (o_awready),
		.i_wvalid  (i_wvalid),
		.i_wdata   (i_wdata),
		.o_wready  (o_wready),
		.i_bready  (i_bready),
		.o_bvalid  (o_bvalid),
		.o_bresp   (o_bresp),
		.o_uop     (dec_uop.source)
	);

	uop_fifo u_uop_fifo (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_uop   (dec_uop.sink),
		.o_uop   (head_uop.source)
	);

	uop_axi_reader u_uop_axi_reader (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_arvalid (i_arvalid),
		.i_araddr  (i_araddr),
		.o_arready (o_arready),
		.i_rready  (i_rready),
		.o_rvalid  (o_rvalid),
		.o_rdata   (o_rdata),
		.o_rresp   (o_rresp),
		.i_uop     (head_uop.sink)
	);

endmodule

//--- rv_decode_stage.sv
module rv_decode_stage (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_awvalid,
	input  rv_dec_pkg::pc_t    i_awaddr,
	output logic               o_awready,
	input  logic               i_wvalid,
	input  rv_dec_pkg::instr_t i_wdata,
	output logic               o_wready,
	input  logic               i_bready,
	output logic               o_bvalid,
	output rv_dec_pkg::resp_t  o_bresp,
	uop_if.source              o_uop
);

	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_IMM32 = 7'b0011011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_REG32 = 7'b0111011;
	localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

	logic aw_got;
	logic w_got;
	logic aw_hs;
	logic w_hs;
	logic can_accept;
	logic done;
	rv_dec_pkg::pc_t pc_q;
	rv_dec_pkg::instr_t instr_q;
	rv_dec_pkg::pc_t cur_pc;
	rv_dec_pkg::instr_t cur_instr;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_dec_pkg::alu_op_t r_alu;
	logic r_ok;
	rv_dec_pkg::alu_op_t i_alu;
	logic i_ok;
	logic bad;

	rv_dec_pkg::reg_idx_t dec_rd;
	rv_dec_pkg::reg_idx_t dec_rs1;
	rv_dec_pkg::reg_idx_t dec_rs2;
	rv_dec_pkg::alu_op_t dec_alu;
	rv_dec_pkg::instr_type_t dec_type;
	rv_dec_pkg::mem_access_t dec_macc;
	rv_dec_pkg::mem_size_t dec_msize;
	logic dec_rw;
	logic dec_ecall;
	logic dec_shift;
	logic dec_pc_add;
	rv_dec_pkg::imm_t dec_imm;

	// a new word waits for the B response and a free output register
	assign can_accept = !o_bvalid && (!o_uop.valid || o_uop.ready);
	assign o_awready = !aw_got && can_accept;
	assign o_wready = !w_got && can_accept;
	assign aw_hs = i_awvalid && o_awready;
	assign w_hs = i_wvalid && o_wready;
	assign done = (aw_got || aw_hs) && (w_got || w_hs);
	assign o_bresp = rv_dec_pkg::OKAY;

	// decode straight from the bus when a channel arrives in the last cycle
	assign cur_pc = aw_got ? pc_q : i_awaddr;
	assign cur_instr = w_got ? instr_q : i_wdata;

	assign opcode = cur_instr[6:0];
	assign funct3 = cur_instr[14:12];
	assign funct7 = cur_instr[31:25];

	// register-register operations, shared by the 32- and 64-bit forms
	always_comb begin
		r_alu = rv_dec_pkg::ALU_NONE;
		r_ok = 1'b1;
		if (funct7 == 7'h01) begin
			case (funct3)
				3'd0: r_alu = rv_dec_pkg::MUL;
				3'd1: r_alu = rv_dec_pkg::MULH;
				3'd2: r_alu = rv_dec_pkg::MULHSU;
				3'd3: r_alu = rv_dec_pkg::MULHU;
				3'd4: r_alu = rv_dec_pkg::DIV;
				3'd5: r_alu = rv_dec_pkg::DIVU;
				3'd6: r_alu = rv_dec_pkg::REM;
				default: r_alu = rv_dec_pkg::REMU;
			endcase
		end else if (funct7 == 7'h00) begin
			case (funct3)
				3'd0: r_alu = rv_dec_pkg::ADD;
				3'd1: r_alu = rv_dec_pkg::SLL;
				3'd2: r_alu = rv_dec_pkg::LESS;
				3'd3: r_alu = rv_dec_pkg::LESSU;
				3'd4: r_alu = rv_dec_pkg::XOR;
				3'd5: r_alu = rv_dec_pkg::SRL;
				3'd6: r_alu = rv_dec_pkg::OR;
				default: r_alu = rv_dec_pkg::AND;
			endcase
		end else if (funct7 == 7'h20 && funct3 == 3'd0) begin
			r_alu = rv_dec_pkg::SUB;
		end else if (funct7 == 7'h20 && funct3 == 3'd5) begin
			r_alu = rv_dec_pkg::SRA;
		end else begin
			r_ok = 1'b0;
		end
	end

	// immediate operations, shifts check the upper six bits
	always_comb begin
		i_alu = rv_dec_pkg::ALU_NONE;
		i_ok = 1'b1;
		case (funct3)
			3'd0: i_alu = rv_dec_pkg::ADD;
			3'd1: begin
				i_alu = rv_dec_pkg::SLL;
				i_ok = (cur_instr[31:26] == 6'b000000);
			end
			3'd2: i_alu = rv_dec_pkg::LESS;
			3'd3: i_alu = rv_dec_pkg::SLTIU;
			3'd4: i_alu = rv_dec_pkg::XOR;
			3'd5: begin
				if (cur_instr[31:26] == 6'b000000)
					i_alu = rv_dec_pkg::SRL;
				else if (cur_instr[31:26] == 6'b010000)
					i_alu = rv_dec_pkg::SRA;
				else
					i_ok = 1'b0;
			end
			3'd6: i_alu = rv_dec_pkg::OR;
			default: i_alu = rv_dec_pkg::AND;
		endcase
	end

	always_comb begin
		dec_rd = cur_instr[11:7];
		dec_rs1 = cur_instr[19:15];
		dec_rs2 = cur_instr[24:20];
		dec_alu = rv_dec_pkg::ALU_NONE;
		dec_type = rv_dec_pkg::T_NONE;
		dec_macc = rv_dec_pkg::MA_NONE;
		dec_msize = rv_dec_pkg::MS_NONE;
		dec_rw = 1'b1;
		dec_ecall = 1'b0;
		dec_shift = 1'b0;
		dec_pc_add = 1'b0;
		bad = 1'b0;
		case (opcode)
			OP_JAL: begin
				dec_alu = rv_dec_pkg::JUMP;
				dec_type = rv_dec_pkg::T_UJ;
			end
			OP_LUI: begin
				dec_alu = rv_dec_pkg::IMMVAL;
				dec_type = rv_dec_pkg::T_U;
			end
			OP_AUIPC: begin
				dec_alu = rv_dec_pkg::IMMVAL;
				dec_type = rv_dec_pkg::T_U;
				dec_pc_add = 1'b1;
			end
			OP_JALR: begin
				dec_alu = rv_dec_pkg::JUMP;
				dec_type = rv_dec_pkg::T_I;
				dec_pc_add = 1'b1;
				bad = (funct3 != 3'd0);
			end
			OP_BRANCH: begin
				dec_type = rv_dec_pkg::T_SB;
				dec_rw = 1'b0;
				case (funct3)
					3'd0: dec_alu = rv_dec_pkg::EQUAL;
					3'd1: dec_alu = rv_dec_pkg::NEQ;
					3'd4: dec_alu = rv_dec_pkg::LESS;
					3'd5: dec_alu = rv_dec_pkg::GTE;
					3'd6: dec_alu = rv_dec_pkg::LESSU;
					3'd7: dec_alu = rv_dec_pkg::GTEU;
					default: bad = 1'b1;
				endcase
			end
			OP_LOAD: begin
				dec_alu = rv_dec_pkg::ADD;
				dec_type = rv_dec_pkg::T_I;
				dec_macc = rv_dec_pkg::MA_READ;
				dec_msize = rv_dec_pkg::mem_size_t'(funct3 + 3'd1);
				bad = (funct3 == 3'd7);
			end
			OP_STORE: begin
				dec_alu = rv_dec_pkg::ADD;
				dec_type = rv_dec_pkg::T_S;
				dec_macc = rv_dec_pkg::MA_WRITE;
				dec_msize = rv_dec_pkg::mem_size_t'(funct3 + 3'd1);
				dec_rw = 1'b0;
				bad = funct3[2];
			end
			OP_REG: begin
				dec_alu = r_alu;
				dec_type = rv_dec_pkg::T_R;
				bad = !r_ok;
			end
			OP_REG32: begin
				dec_alu = r_alu;
				dec_type = rv_dec_pkg::T_R;
				// only add/sub/shifts and mul/div/rem have a W-form
				if (funct7 == 7'h01)
					bad = !r_ok || !(funct3 inside {3'd0, 3'd4, 3'd5, 3'd6, 3'd7});
				else
					bad = !r_ok || !(funct3 inside {3'd0, 3'd1, 3'd5});
			end
			OP_IMM: begin
				dec_alu = i_alu;
				dec_type = rv_dec_pkg::T_I;
				dec_shift = (funct3 == 3'd1) || (funct3 == 3'd5);
				bad = !i_ok;
			end
			OP_IMM32: begin
				dec_alu = i_alu;
				dec_type = rv_dec_pkg::T_I;
				dec_shift = (funct3 == 3'd1) || (funct3 == 3'd5);
				// W shifts take five bits of shamt
				bad = !i_ok || !(funct3 inside {3'd0, 3'd1, 3'd5}) ||
					(funct3 != 3'd0 && cur_instr[25]);
			end
			default: bad = 1'b1;
		endcase

		if (bad) begin
			dec_alu = rv_dec_pkg::ALU_NONE;
			dec_type = rv_dec_pkg::T_NONE;
			dec_macc = rv_dec_pkg::MA_NONE;
			dec_msize = rv_dec_pkg::MS_NONE;
			dec_rw = 1'b0;
			dec_shift = 1'b0;
			dec_pc_add = 1'b0;
		end

		if (cur_instr == ECALL_WORD) begin
			dec_rd = '0;
			dec_rs1 = '0;
			dec_rs2 = '0;
			dec_ecall = 1'b1;
		end
	end

	rv_imm_gen u_imm_gen (
		.i_instr     (cur_instr),
		.i_pc        (cur_pc),
		.i_type      (dec_type),
		.i_shift_imm (dec_shift),
		.i_pc_add    (dec_pc_add),
		.o_imm       (dec_imm)
	);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			aw_got <= 1'b0;
			w_got <= 1'b0;
			o_bvalid <= 1'b0;
			o_uop.valid <= 1'b0;
		end else begin
			if (done) begin
				aw_got <= 1'b0;
				w_got <= 1'b0;
			end else begin
				if (aw_hs)
					aw_got <= 1'b1;
				if (w_hs)
					w_got <= 1'b1;
			end
			if (done)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;
			if (done)
				o_uop.valid <= 1'b1;
			else if (o_uop.ready)
				o_uop.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			pc_q <= i_awaddr;
		if (w_hs)
			instr_q <= i_wdata;
		if (done) begin
			o_uop.rd <= dec_rd;
			o_uop.rs1 <= dec_rs1;
			o_uop.rs2 <= dec_rs2;
			o_uop.imm <= dec_imm;
			o_uop.alu_op <= dec_alu;
			o_uop.instr_type <= dec_type;
			o_uop.mem_access <= dec_macc;
			o_uop.mem_size <= dec_msize;
			o_uop.reg_write <= dec_rw;
			o_uop.ecall <= dec_ecall;
		end
	end

endmodule

//--- rv_imm_gen.sv
`include "rv_dec_params.svh"

module rv_imm_gen (
	input  rv_dec_pkg::instr_t      i_instr,
	input  rv_dec_pkg::pc_t         i_pc,
	input  rv_dec_pkg::instr_type_t i_type,
	input  logic                    i_shift_imm,
	input  logic                    i_pc_add,
	output rv_dec_pkg::imm_t        o_imm
);

	rv_dec_pkg::imm_t imm_i;
	rv_dec_pkg::imm_t imm_s;
	rv_dec_pkg::imm_t imm_sb;
	rv_dec_pkg::imm_t imm_u;
	rv_dec_pkg::imm_t imm_uj;
	rv_dec_pkg::imm_t imm_sh;
	rv_dec_pkg::imm_t base;
	logic add_pc;

	// sign extension through a sized cast of a signed value
	assign imm_i = `RV_XLEN'($signed(i_instr[31:20]));
	assign imm_s = `RV_XLEN'($signed({i_instr[31:25], i_instr[11:7]}));
	assign imm_sb = `RV_XLEN'($signed({i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0}));
	assign imm_u = `RV_XLEN'($signed({i_instr[31:12], 12'b0}));
	assign imm_uj = `RV_XLEN'($signed({i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0}));

	// 6-bit shamt for RV64 shifts
	assign imm_sh = `RV_XLEN'(i_instr[25:20]);

	always_comb begin
		case (i_type)
			rv_dec_pkg::T_I:  base = imm_i;
			rv_dec_pkg::T_S:  base = imm_s;
			rv_dec_pkg::T_SB: base = imm_sb;
			rv_dec_pkg::T_U:  base = imm_u;
			rv_dec_pkg::T_UJ: base = imm_uj;
			default:          base = '0;
		endcase
	end

	// auipc and jalr ask for the pc through i_pc_add
	assign add_pc = (i_type == rv_dec_pkg::T_SB) || (i_type == rv_dec_pkg::T_UJ) || i_pc_add;

	assign o_imm = i_shift_imm ? imm_sh : (add_pc ? base + i_pc : base);

endmodule

//--- tb_rv_dec_ref.svh
`ifndef TB_RV_DEC_REF_SVH
`define TB_RV_DEC_REF_SVH

// base ALU operation by funct3, shared by register and immediate forms
function automatic rv_dec_pkg::alu_op_t base_alu(input logic [2:0] f3);
	case (f3)
		3'd0: return rv_dec_pkg::ADD;
		3'd1: return rv_dec_pkg::SLL;
		3'd2: return rv_dec_pkg::LESS;
		3'd3: return rv_dec_pkg::LESSU;
		3'd4: return rv_dec_pkg::XOR;
		3'd5: return rv_dec_pkg::SRL;
		3'd6: return rv_dec_pkg::OR;
		default: return rv_dec_pkg::AND;
	endcase
endfunction

function automatic rv_dec_pkg::alu_op_t m_alu(input logic [2:0] f3);
	case (f3)
		3'd0: return rv_dec_pkg::MUL;
		3'd1: return rv_dec_pkg::MULH;
		3'd2: return rv_dec_pkg::MULHSU;
		3'd3: return rv_dec_pkg::MULHU;
		3'd4: return rv_dec_pkg::DIV;
		3'd5: return rv_dec_pkg::DIVU;
		3'd6: return rv_dec_pkg::REM;
		default: return rv_dec_pkg::REMU;
	endcase
endfunction

function automatic rv_dec_pkg::mem_size_t size_of(input logic [2:0] f3);
	case (f3)
		3'd0: return rv_dec_pkg::BYTE;
		3'd1: return rv_dec_pkg::HALF;
		3'd2: return rv_dec_pkg::WORD;
		3'd3: return rv_dec_pkg::DOUBLE;
		3'd4: return rv_dec_pkg::UBYTE;
		3'd5: return rv_dec_pkg::UHALF;
		3'd6: return rv_dec_pkg::UWORD;
		default: return rv_dec_pkg::MS_NONE;
	endcase
endfunction

// expected control word and immediate of one valid instruction
function automatic void ref_decode(input rv_dec_pkg::instr_t ins, input rv_dec_pkg::pc_t pc,
	output rv_dec_pkg::word_t cw, output rv_dec_pkg::imm_t imm);
	logic [2:0] f3;
	rv_dec_pkg::alu_op_t alu;
	rv_dec_pkg::instr_type_t typ;
	rv_dec_pkg::mem_access_t ma;
	rv_dec_pkg::mem_size_t ms;
	logic rw;
	rv_dec_pkg::imm_t ii;
	f3 = ins[14:12];
	alu = rv_dec_pkg::ALU_NONE;
	typ = rv_dec_pkg::T_NONE;
	ma = rv_dec_pkg::MA_NONE;
	ms = rv_dec_pkg::MS_NONE;
	rw = 1'b1;
	ii = {{20{ins[31]}}, ins[31:20]};
	imm = '0;
	case (ins[6:0])
		7'h37: begin
			alu = rv_dec_pkg::IMMVAL;
			typ = rv_dec_pkg::T_U;
			imm = {ins[31:12], 12'b0};
		end
		7'h17: begin
			alu = rv_dec_pkg::IMMVAL;
			typ = rv_dec_pkg::T_U;
			imm = {ins[31:12], 12'b0} + pc;
		end
		7'h6f: begin
			alu = rv_dec_pkg::JUMP;
			typ = rv_dec_pkg::T_UJ;
			imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0} + pc;
		end
		7'h67: begin
			alu = rv_dec_pkg::JUMP;
			typ = rv_dec_pkg::T_I;
			imm = ii + pc;
		end
		7'h63: begin
			typ = rv_dec_pkg::T_SB;
			rw = 1'b0;
			imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0} + pc;
			case (f3)
				3'd0: alu = rv_dec_pkg::EQUAL;
				3'd1: alu = rv_dec_pkg::NEQ;
				3'd4: alu = rv_dec_pkg::LESS;
				3'd5: alu = rv_dec_pkg::GTE;
				3'd6: alu = rv_dec_pkg::LESSU;
				default: alu = rv_dec_pkg::GTEU;
			endcase
		end
		7'h03, 7'h23: begin
			alu = rv_dec_pkg::ADD;
			ms = size_of(f3);
			if (ins[5]) begin
				typ = rv_dec_pkg::T_S;
				ma = rv_dec_pkg::MA_WRITE;
				rw = 1'b0;
				imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			end else begin
				typ = rv_dec_pkg::T_I;
				ma = rv_dec_pkg::MA_READ;
				imm = ii;
			end
		end
		7'h33, 7'h3b: begin
			typ = rv_dec_pkg::T_R;
			if (ins[31:25] == 7'h01)
				alu = m_alu(f3);
			else if (ins[31:25] == 7'h20)
				alu = (f3 == 3'd0) ? rv_dec_pkg::SUB : rv_dec_pkg::SRA;
			else
				alu = base_alu(f3);
		end
		default: begin
			// immediate operations, shifts carry the bare shift amount
			typ = rv_dec_pkg::T_I;
			imm = ii;
			alu = (f3 == 3'd3) ? rv_dec_pkg::SLTIU : base_alu(f3);
			if (f3 == 3'd1 || f3 == 3'd5)
				imm = {26'b0, ins[25:20]};
			if (f3 == 3'd5 && ins[30])
				alu = rv_dec_pkg::SRA;
		end
	endcase
	cw = {3'b000, rw, ms, ma, typ, alu, ins[24:20], ins[19:15], ins[11:7]};
	if (ins == 32'h0000_0073) begin
		cw = 32'h2000_0000;
		imm = '0;
	end
endfunction

task automatic check_word(input string name, input rv_dec_pkg::word_t exp,
	input rv_dec_pkg::word_t act);
	if (exp !== act) begin
		$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_imm(input string name, input rv_dec_pkg::imm_t exp,
	input rv_dec_pkg::imm_t act);
	if (exp !== act) begin
		$display("[ERROR] %s imm: expected %h, actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_resp(input string name, input rv_dec_pkg::resp_t exp,
	input rv_dec_pkg::resp_t act);
	if (exp !== act) begin
		$display("[ERROR] %s resp: expected %s, actual %s", name, exp.name(), act.name());
		errors++;
	end
endtask

`endif

//--- tb_rv_dec.sv
`include "rv_dec_params.svh"

module tb_rv_dec;

	// number of issued instructions sizes the timeout
	localparam int N_INSTR = 124;
	localparam int LIMIT = 200 * N_INSTR + 500;

	logic clk;
	logic i_rst_n;
	logic i_awvalid;
	rv_dec_pkg::pc_t i_awaddr;
	logic o_awready;
	logic i_wvalid;
	rv_dec_pkg::instr_t i_wdata;
	logic o_wready;
	logic i_bready;
	logic o_bvalid;
	rv_dec_pkg::resp_t o_bresp;
	logic i_arvalid;
	rv_dec_pkg::word_t i_araddr;
	logic o_arready;
	logic i_rready;
	logic o_rvalid;
	rv_dec_pkg::word_t o_rdata;
	rv_dec_pkg::resp_t o_rresp;

	int errors;
	int cycles;
	integer seed;
	rv_dec_pkg::word_t exp_cw[$];
	rv_dec_pkg::imm_t exp_imm[$];
	logic [2:0] br_f3[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	logic [6:0] w_f7[10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h20, 7'h01, 7'h01, 7'h01,
		7'h01, 7'h01};
	logic [2:0] w_f3[10] = '{3'd0, 3'd0, 3'd1, 3'd5, 3'd5, 3'd0, 3'd4, 3'd5, 3'd6, 3'd7};

	`include "tb_rv_dec_ref.svh"

	rv_dec_top u_rv_dec_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout: DUT stopped answering after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic axi_write(input rv_dec_pkg::pc_t pc, input rv_dec_pkg::instr_t ins);
		logic aw_done;
		logic w_done;
		logic b_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		b_done = 1'b0;
		@(posedge clk);
		#2;
		i_awvalid = 1'b1;
		i_awaddr = pc;
		i_wvalid = 1'b1;
		i_wdata = ins;
		while (!(aw_done && w_done)) begin
			@(negedge clk);
			aw_done = aw_done || (i_awvalid && o_awready);
			w_done = w_done || (i_wvalid && o_wready);
			@(posedge clk);
			#2;
			i_awvalid = i_awvalid && !aw_done;
			i_wvalid = i_wvalid && !w_done;
		end
		while (!b_done) begin
			@(negedge clk);
			b_done = o_bvalid;
			if (b_done)
				check_resp("write B", rv_dec_pkg::OKAY, o_bresp);
			@(posedge clk);
			#2;
		end
	endtask

	task automatic axi_read(input rv_dec_pkg::word_t addr, output rv_dec_pkg::word_t data,
		output rv_dec_pkg::resp_t resp);
		logic ar_done;
		logic r_done;
		ar_done = 1'b0;
		r_done = 1'b0;
		@(posedge clk);
		#2;
		i_arvalid = 1'b1;
		i_araddr = addr;
		while (!r_done) begin
			@(negedge clk);
			if (ar_done && o_rvalid) begin
				r_done = 1'b1;
				data = o_rdata;
				resp = o_rresp;
			end
			ar_done = ar_done || (i_arvalid && o_arready);
			@(posedge clk);
			#2;
			i_arvalid = i_arvalid && !ar_done;
		end
	endtask

	// pops the oldest expected micro-op and compares both words
	task automatic read_check(input string name);
		rv_dec_pkg::word_t d;
		rv_dec_pkg::resp_t r;
		axi_read(`RV_REG_CTRL, d, r);
		check_resp(name, rv_dec_pkg::OKAY, r);
		check_word(name, exp_cw.pop_front(), d);
		axi_read(`RV_REG_IMM, d, r);
		check_resp(name, rv_dec_pkg::OKAY, r);
		check_imm(name, exp_imm.pop_front(), rv_dec_pkg::imm_t'(d));
	endtask

	task automatic issue(input rv_dec_pkg::instr_t ins, input rv_dec_pkg::pc_t pc);
		rv_dec_pkg::word_t cw;
		rv_dec_pkg::imm_t imm;
		ref_decode(ins, pc, cw, imm);
		exp_cw.push_back(cw);
		exp_imm.push_back(imm);
		axi_write(pc, ins);
	endtask

	task automatic run_one(input string name, input rv_dec_pkg::instr_t ins);
		issue(ins, 32'h0000_4000);
		read_check(name);
	endtask

	function automatic rv_dec_pkg::instr_t rand_instr();
		logic [31:0] r;
		logic [31:0] k;
		logic [2:0] f3;
		r = $random(seed);
		k = $random(seed) & 32'h7fff_ffff;
		f3 = 3'(k[9:7]);
		case (k % 9)
			0: return {r[31:12], r[11:7], 7'h37};
			1: return {r[31:12], r[11:7], 7'h17};
			2: return {r[31:12], r[11:7], 7'h6f};
			3: return {r[31:15], 3'd0, r[11:7], 7'h67};
			4: return {r[31:15], br_f3[k[6:4] % 6], r[11:7], 7'h63};
			5: return {r[31:15], (f3 == 3'd7) ? 3'd6 : f3, r[11:7], 7'h03};
			6: return {r[31:15], 1'b0, f3[1:0], r[11:7], 7'h23};
			7: begin
				if (k[10])
					return {7'h01, r[24:15], f3, r[11:7], 7'h33};
				else if (k[11] && (f3 == 3'd0 || f3 == 3'd5))
					return {7'h20, r[24:15], f3, r[11:7], 7'h33};
				return {7'h00, r[24:15], f3, r[11:7], 7'h33};
			end
			default: begin
				if (f3 == 3'd1 || f3 == 3'd5)
					return {1'b0, k[12] && f3[2], 4'b0, r[25:15], f3, r[11:7], 7'h13};
				return {r[31:15], f3, r[11:7], 7'h13};
			end
		endcase
	endfunction

	initial begin
		rv_dec_pkg::word_t d;
		rv_dec_pkg::resp_t r;
		errors = 0;
		cycles = 0;
		seed = 51871;
		i_rst_n = 1'b0;
		i_awvalid = 1'b0;
		i_awaddr = '0;
		i_wvalid = 1'b0;
		i_wdata = '0;
		i_bready = 1'b1;
		i_arvalid = 1'b0;
		i_araddr = '0;
		i_rready = 1'b1;
		repeat (5) @(posedge clk);
		#2;
		i_rst_n = 1'b1;

		// one of each opcode class
		run_one("lui", {20'habcde, 5'd3, 7'h37});
		run_one("auipc", {20'h80001, 5'd4, 7'h17});
		run_one("jal", {1'b1, 10'h3f0, 1'b1, 8'hff, 5'd1, 7'h6f});
		run_one("jalr", {12'hff0, 5'd2, 3'd0, 5'd1, 7'h67});
		for (int i = 0; i < 6; i++)
			run_one($sformatf("branch %0d", i), {7'h7f, 5'd6, 5'd7, br_f3[i], 5'h1e, 7'h63});
		for (int i = 0; i < 7; i++)
			run_one($sformatf("load %0d", i), {12'h804, 5'd8, 3'(i), 5'd9, 7'h03});
		for (int i = 0; i < 4; i++)
			run_one($sformatf("store %0d", i), {7'h40, 5'd10, 5'd11, 3'(i), 5'd12, 7'h23});
		for (int i = 0; i < 8; i++) begin
			run_one($sformatf("reg %0d", i), {7'h00, 5'd13, 5'd14, 3'(i), 5'd15, 7'h33});
			run_one($sformatf("mul %0d", i), {7'h01, 5'd16, 5'd17, 3'(i), 5'd18, 7'h33});
		end
		run_one("sub", {7'h20, 5'd19, 5'd20, 3'd0, 5'd21, 7'h33});
		run_one("sra", {7'h20, 5'd19, 5'd20, 3'd5, 5'd21, 7'h33});
		for (int i = 0; i < 10; i++)
			run_one($sformatf("wform %0d", i), {w_f7[i], 5'd22, 5'd23, w_f3[i], 5'd24, 7'h3b});
		for (int i = 0; i < 8; i++)
			if (i != 1 && i != 5)
				run_one($sformatf("imm %0d", i), {12'hf9c, 5'd25, 3'(i), 5'd26, 7'h13});
		run_one("slli", {6'h00, 6'd40, 5'd27, 3'd1, 5'd28, 7'h13});
		run_one("srli", {6'h00, 6'd33, 5'd27, 3'd5, 5'd28, 7'h13});
		run_one("srai", {6'h10, 6'd7, 5'd27, 3'd5, 5'd28, 7'h13});
		run_one("addiw", {12'h7ff, 5'd29, 3'd0, 5'd30, 7'h1b});
		run_one("slliw", {7'h00, 5'd31, 5'd29, 3'd1, 5'd30, 7'h1b});
		run_one("sraiw", {7'h20, 5'd3, 5'd29, 3'd5, 5'd30, 7'h1b});
		run_one("ecall", 32'h0000_0073);

		// back-to-back writes stall on a full FIFO until the reader starts
		fork
			for (int i = 0; i < 60; i++)
				issue(rand_instr(), $random(seed));
			begin
				repeat (30) @(posedge clk);
				for (int i = 0; i < 60; i++)
					read_check($sformatf("random %0d", i));
			end
		join

		// immediate read on an empty FIFO
		axi_read(`RV_REG_IMM, d, r);
		check_resp("empty imm", rv_dec_pkg::SLVERR, r);
		check_word("empty imm", '0, d);

		issue({12'h123, 5'd1, 3'd0, 5'd2, 7'h13}, 32'h100);
		issue({7'h01, 5'd3, 5'd4, 3'd4, 5'd5, 7'h33}, 32'h104);

		// unmapped offset while the FIFO holds entries
		axi_read(32'h8, d, r);
		check_resp("bad offset", rv_dec_pkg::SLVERR, r);
		check_word("bad offset", '0, d);

		// control reads leave the head in place
		axi_read(`RV_REG_CTRL, d, r);
		check_resp("peek 1", rv_dec_pkg::OKAY, r);
		check_word("peek 1", exp_cw[0], d);
		read_check("peek 2");
		read_check("next head");

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- uop_axi_reader.sv
`include "rv_dec_params.svh"

module uop_axi_reader (
	input  logic              clk,
	input  logic              i_rst_n,
	input  logic              i_arvalid,
	input  rv_dec_pkg::word_t i_araddr,
	output logic              o_arready,
	input  logic              i_rready,
	output logic              o_rvalid,
	output rv_dec_pkg::word_t o_rdata,
	output rv_dec_pkg::resp_t o_rresp,
	uop_if.sink               i_uop
);

	logic ar_hs;
	logic is_ctrl;
	logic is_imm;
	rv_dec_pkg::word_t ctrl_word;

	// one read in flight, AR closes while R is pending
	assign o_arready = !o_rvalid;
	assign ar_hs = i_arvalid && o_arready;

	assign is_ctrl = (i_araddr == `RV_REG_CTRL);
	assign is_imm = (i_araddr == `RV_REG_IMM);

	// the immediate read retires the head
	assign i_uop.ready = ar_hs && is_imm && i_uop.valid;

	always_comb begin
		ctrl_word = '0;
		ctrl_word[rv_dec_pkg::CW_RD_LSB +: $bits(rv_dec_pkg::reg_idx_t)] = i_uop.rd;
		ctrl_word[rv_dec_pkg::CW_RS1_LSB +: $bits(rv_dec_pkg::reg_idx_t)] = i_uop.rs1;
		ctrl_word[rv_dec_pkg::CW_RS2_LSB +: $bits(rv_dec_pkg::reg_idx_t)] = i_uop.rs2;
		ctrl_word[rv_dec_pkg::CW_ALU_LSB +: $bits(rv_dec_pkg::alu_op_t)] = i_uop.alu_op;
		ctrl_word[rv_dec_pkg::CW_TYPE_LSB +: $bits(rv_dec_pkg::instr_type_t)] =
			i_uop.instr_type;
		ctrl_word[rv_dec_pkg::CW_MACC_LSB +: $bits(rv_dec_pkg::mem_access_t)] =
			i_uop.mem_access;
		ctrl_word[rv_dec_pkg::CW_MSIZE_LSB +: $bits(rv_dec_pkg::mem_size_t)] =
			i_uop.mem_size;
		ctrl_word[rv_dec_pkg::CW_RW_BIT] = i_uop.reg_write;
		ctrl_word[rv_dec_pkg::CW_ECALL_BIT] = i_uop.ecall;
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_rvalid <= 1'b0;
		else if (ar_hs)
			o_rvalid <= 1'b1;
		else if (i_rready)
			o_rvalid <= 1'b0;
	end

	// response captured at the AR handshake and held until R completes
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			if (i_uop.valid && is_ctrl) begin
				o_rdata <= ctrl_word;
				o_rresp <= rv_dec_pkg::OKAY;
			end else if (i_uop.valid && is_imm) begin
				o_rdata <= rv_dec_pkg::word_t'(i_uop.imm);
				o_rresp <= rv_dec_pkg::OKAY;
			end else begin
				// empty FIFO or unmapped offset
				o_rdata <= '0;
				o_rresp <= rv_dec_pkg::SLVERR;
			end
		end
	end

endmodule

//--- uop_fifo.sv
`include "rv_dec_params.svh"

module uop_fifo (
	input  logic  clk,
	input  logic  i_rst_n,
	uop_if.sink   i_uop,
	uop_if.source o_uop
);

	localparam int PTR_W = $clog2(`RV_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`RV_FIFO_DEPTH + 1);

	rv_dec_pkg::reg_idx_t rd_mem [`RV_FIFO_DEPTH];
	rv_dec_pkg::reg_idx_t rs1_mem [`RV_FIFO_DEPTH];
	rv_dec_pkg::reg_idx_t rs2_mem [`RV_FIFO_DEPTH];
	rv_dec_pkg::imm_t imm_mem [`RV_FIFO_DEPTH];
	rv_dec_pkg::alu_op_t alu_mem [`RV_FIFO_DEPTH];
	rv_dec_pkg::instr_type_t type_mem [`RV_FIFO_DEPTH];
	rv_dec_pkg::mem_access_t macc_mem [`RV_FIFO_DEPTH];
	rv_dec_pkg::mem_size_t msize_mem [`RV_FIFO_DEPTH];
	logic rw_mem [`RV_FIFO_DEPTH];
	logic ecall_mem [`RV_FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign i_uop.ready = (count != CNT_W'(`RV_FIFO_DEPTH));
	assign o_uop.valid = (count != '0);
	assign push = i_uop.valid && i_uop.ready;
	assign pop = o_uop.valid && o_uop.ready;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(`RV_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(`RV_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			rd_mem[wr_ptr] <= i_uop.rd;
			rs1_mem[wr_ptr] <= i_uop.rs1;
			rs2_mem[wr_ptr] <= i_uop.rs2;
			imm_mem[wr_ptr] <= i_uop.imm;
			alu_mem[wr_ptr] <= i_uop.alu_op;
			type_mem[wr_ptr] <= i_uop.instr_type;
			macc_mem[wr_ptr] <= i_uop.mem_access;
			msize_mem[wr_ptr] <= i_uop.mem_size;
			rw_mem[wr_ptr] <= i_uop.reg_write;
			ecall_mem[wr_ptr] <= i_uop.ecall;
		end
	end

	assign o_uop.rd = rd_mem[rd_ptr];
	assign o_uop.rs1 = rs1_mem[rd_ptr];
	assign o_uop.rs2 = rs2_mem[rd_ptr];
	assign o_uop.imm = imm_mem[rd_ptr];
	assign o_uop.alu_op = alu_mem[rd_ptr];
	assign o_uop.instr_type = type_mem[rd_ptr];
	assign o_uop.mem_access = macc_mem[rd_ptr];
	assign o_uop.mem_size = msize_mem[rd_ptr];
	assign o_uop.reg_write = rw_mem[rd_ptr];
	assign o_uop.ecall = ecall_mem[rd_ptr];

endmodule

//--- uop_if.sv
// one decoded micro-op with a valid/ready handshake
interface uop_if;

	logic valid;
	logic ready;

	rv_dec_pkg::reg_idx_t rd;
	rv_dec_pkg::reg_idx_t rs1;
	rv_dec_pkg::reg_idx_t rs2;
	rv_dec_pkg::imm_t imm;
	rv_dec_pkg::alu_op_t alu_op;
	rv_dec_pkg::instr_type_t instr_type;
	rv_dec_pkg::mem_access_t mem_access;
	rv_dec_pkg::mem_size_t mem_size;
	logic reg_write;
	logic ecall;

	modport source (
		output valid, rd, rs1, rs2, imm,
		output alu_op, instr_type, mem_access, mem_size,
		output reg_write, ecall,
		input ready
	);

	modport sink (
		input valid, rd, rs1, rs2, imm,
		input alu_op, instr_type, mem_access, mem_size,
		input reg_write, ecall,
		output ready
	);

endinterface
